// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+dv
hw/rv_exec_pkg.sv
hw/instr_decoder.sv
hw/alu_decoder.sv
hw/exec_fsm.sv
hw/shift_counter.sv
hw/alu_core.sv
hw/serial_shifter.sv
hw/rv_exec_top.sv
dv/rv_exec_tb.sv

// File: dv/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Expected result, illegal flag and latency of one instruction. Latency is counted
// in falling edges from the accepting edge up to the one that sees done_o high.
function automatic void ref_exec(input logic [31:0] instr, input logic [31:0] a,
                                 input logic [31:0] b_reg, output logic [31:0] res,
                                 output logic ill, output int cycles);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] b;
    logic [4:0]  sh;
    opc    = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    b      = (opc == OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : b_reg;
    sh     = b[4:0];
    res    = '0;
    ill    = 1'b0;
    cycles = 2;
    if (opc == OPC_BRANCH) begin
        res = a - b;
    end else if (opc == OPC_STORE) begin
        res = a + b;
    end else if (opc != OPC_OP && opc != OPC_OP_IMM) begin
        ill = 1'b1;
    end else if (f3 == 3'd1 || f3 == 3'd5) begin
        if (f7 == 7'h00 && f3 == 3'd1) res = a << sh;
        else if (f7 == 7'h00) res = a >> sh;
        else if (f7 == FUNCT7_ALT && f3 == 3'd5) res = $signed(a) >>> sh;
        else ill = 1'b1;
        if (!ill) cycles = 3 + int'(sh); // One cycle per shifted bit
    end else if (opc == OPC_OP && f7 == FUNCT7_ALT) begin
        if (f3 == 3'd0) res = a - b;
        else ill = 1'b1;
    end else if (opc == OPC_OP && f7 != 7'h00) begin
        ill = 1'b1;
    end else begin
        case (f3)
            3'd0:    res = a + b;
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
    end
endfunction

`endif

// File: dv/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb
    import rv_exec_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int DONE_LIMIT   = 64; // Longest shift needs 34
    localparam int N_RAND       = 60;
    localparam int N_SHIFT      = 6 * 32;
    localparam int N_ILLEGAL    = 40;
    localparam int N_BR_ST      = 20;
    localparam int N_DROP       = 10;
    localparam int N_TXN = 2 * N_RAND + N_SHIFT + N_ILLEGAL + N_BR_ST + N_DROP;

    logic            clk;
    logic            arst_n;
    logic            start;
    instr_u          instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] result;
    logic            illegal;
    int              errors;
    int              txns;

    rv_exec_top dut_i (.clk_i(clk), .arst_n_i(arst_n), .start_i(start), .instr_i(instr),
                       .rs1_i(rs1), .rs2_i(rs2), .busy_o(busy), .done_o(done),
                       .result_o(result), .illegal_o(illegal));

    `include "exec_ref_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((N_TXN * 50 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the watchdog stopped the run at %0t", $time);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("mismatch %s: expected %h actual %h", name, exp, act);
    endtask

    function automatic logic [31:0] rand_operand();
        logic [31:0] sel;
        sel = $urandom;
        case (sel[2:0])
            3'd0:    return 32'h8000_0000; // Corner values for the compares
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'h0;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        logic [31:0] r;
        r = $urandom;
        return {f7, r[4:0], r[9:5], f3, r[14:10], opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3);
        logic [31:0] r;
        r = $urandom;
        return {imm, r[9:5], f3, r[14:10], OPC_OP_IMM};
    endfunction

    // Start held from 1 ns after one rising edge to 1 ns after the next
    task automatic send_instr(input logic [31:0] word, input logic [31:0] a,
                              input logic [31:0] b);
        start = 1'b1;
        instr = word;
        rs1   = a;
        rs2   = b;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string name, output int cyc);
        logic seen;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (busy !== 1'b1) begin
                errors++;
                $display("%s: busy_o went low before done_o", name);
            end
            seen = (done === 1'b1);
        end
        if (!seen) begin
            errors++;
            $display("%s: done_o did not arrive within %0d cycles", name, DONE_LIMIT);
        end
    endtask

    task automatic execute_one(input string name, input logic [31:0] word,
                               input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp_res;
        logic        exp_ill;
        int          exp_cyc;
        int          cyc;
        ref_exec(word, a, b, exp_res, exp_ill, exp_cyc);
        send_instr(word, a, b);
        wait_for_done(name, cyc);
        if (result !== exp_res) report_mismatch({name, " result"}, exp_res, result);
        if (illegal !== exp_ill) report_mismatch({name, " illegal"}, {31'd0, exp_ill},
                                                 {31'd0, illegal});
        if (cyc != exp_cyc) report_mismatch({name, " latency"}, 32'(exp_cyc), 32'(cyc));
        txns++;
        @(posedge clk);
        #1;
    endtask

    task automatic reset_state();
        @(negedge clk);
        if (busy !== 1'b0) report_mismatch("reset busy_o", 32'd0, {31'd0, busy});
        if (done !== 1'b0) report_mismatch("reset done_o", 32'd0, {31'd0, done});
        if (illegal !== 1'b0) report_mismatch("reset illegal_o", 32'd0, {31'd0, illegal});
        if (result !== 32'd0) report_mismatch("reset result_o", 32'd0, result);
        @(posedge clk);
        #1;
    endtask

    task automatic r_type_ops();
        logic [31:0] r;
        logic [6:0]  f7;
        repeat (N_RAND) begin
            r  = $urandom;
            f7 = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? FUNCT7_ALT : 7'h00;
            execute_one("r_type", r_word(f7, r[2:0], OPC_OP), rand_operand(), rand_operand());
        end
    endtask

    task automatic i_type_ops();
        logic [31:0] r;
        repeat (N_RAND) begin
            do begin
                r = $urandom;
            end while (r[14:12] == 3'd1 || r[14:12] == 3'd5); // Shifts run separately
            execute_one("i_type", i_word(r[11:0], r[14:12]), rand_operand(), rand_operand());
        end
    endtask

    task automatic shift_sweep();
        logic [4:0]  sh;
        logic [31:0] r;
        logic [31:0] b;
        for (int n = 0; n < 32; n++) begin
            sh = 5'(n);
            r  = $urandom;
            b  = {r[31:5], sh}; // Upper bits must not matter
            execute_one("sll", r_word(7'h00, 3'd1, OPC_OP), rand_operand(), b);
            execute_one("srl", r_word(7'h00, 3'd5, OPC_OP), rand_operand(), b);
            execute_one("sra", r_word(FUNCT7_ALT, 3'd5, OPC_OP), rand_operand(), b);
            execute_one("slli", i_word({7'h00, sh}, 3'd1), rand_operand(), r);
            execute_one("srli", i_word({7'h00, sh}, 3'd5), rand_operand(), r);
            execute_one("srai", i_word({FUNCT7_ALT, sh}, 3'd5), rand_operand(), r);
        end
    endtask

    task automatic illegal_encodings();
        logic [31:0] r;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [2:0]  f3;
        repeat (N_ILLEGAL) begin
            r   = $urandom;
            f7  = (r[22:16] == 7'h00 || r[22:16] == FUNCT7_ALT) ? 7'h7f : r[22:16];
            f3  = (r[2:0] == 3'd0 || r[2:0] == 3'd5) ? 3'd2 : r[2:0];
            opc = (r[29:23] inside {OPC_OP, OPC_OP_IMM, OPC_BRANCH, OPC_STORE}) ?
                  7'b0000011 : r[29:23];
            case (r[31:30])
                2'd0: execute_one("bad_funct7", r_word(f7, r[2:0], OPC_OP), $urandom, $urandom);
                2'd1: execute_one("bad_alt_op", r_word(FUNCT7_ALT, f3, OPC_OP), $urandom,
                                  $urandom);
                2'd2: execute_one("bad_shift_imm", i_word({f7, r[8:4]}, r[3] ? 3'd5 : 3'd1),
                                  $urandom, $urandom);
                default: execute_one("bad_opcode", r_word(r[15:9], r[2:0], opc), $urandom,
                                     $urandom);
            endcase
        end
    endtask

    task automatic branch_store_ops();
        logic [31:0] r;
        repeat (N_BR_ST / 2) begin
            r = $urandom;
            execute_one("branch", r_word(r[6:0], r[9:7], OPC_BRANCH), rand_operand(),
                        rand_operand());
            execute_one("store", r_word(r[16:10], r[19:17], OPC_STORE), rand_operand(),
                        rand_operand());
        end
    endtask

    task automatic dropped_starts();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] exp_res;
        logic        exp_ill;
        int          exp_cyc;
        int          cyc;
        int          extra;
        repeat (N_DROP) begin
            r    = $urandom;
            word = i_word({r[0] ? FUNCT7_ALT : 7'h00, 2'b11, r[3:1]}, 3'd5); // Long shift
            a    = rand_operand();
            ref_exec(word, a, 32'h0, exp_res, exp_ill, exp_cyc);
            send_instr(word, a, 32'h0);
            send_instr(r_word(7'h00, 3'd0, OPC_OP), ~a, $urandom); // Lands in a busy cycle
            wait_for_done("dropped_start", cyc);
            if (result !== exp_res) report_mismatch("dropped_start result", exp_res, result);
            if (illegal !== exp_ill) report_mismatch("dropped_start illegal",
                                                     {31'd0, exp_ill}, {31'd0, illegal});
            // Count starts one cycle after the accepting edge
            if (cyc != exp_cyc - 1) report_mismatch("dropped_start latency",
                                                    32'(exp_cyc - 1), 32'(cyc));
            extra = 0;
            repeat (40) begin
                @(negedge clk);
                if (done === 1'b1) extra++;
            end
            if (extra != 0) report_mismatch("dropped_start done pulses", 32'd1, 32'(1 + extra));
            txns++;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        start    = 1'b0;
        instr    = '0;
        rs1      = '0;
        rs2      = '0;
        errors   = 0;
        txns     = 0;
        void'($urandom(32'hd67b));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_state();
        r_type_ops();
        i_type_ops();
        shift_sweep();
        illegal_encodings();
        branch_store_ops();
        dropped_starts();
        $display("transactions: %0d, errors: %0d", txns, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hw/alu_core.sv
`timescale 1ns/1ps

module alu_core
    import rv_exec_pkg::*;
(
    input  logic [XLEN-1:0] op_a_i,        // rs1
    input  logic [XLEN-1:0] op_b_i,        // rs2 or immediate
    input  logic [3:0]      alu_control_i,
    output logic [XLEN-1:0] result_o
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = ($signed(op_a_i) < $signed(op_b_i));
    assign lt_unsigned = (op_a_i < op_b_i);

    always_comb begin
        case (alu_control_i)
            ALU_ADD:  result_o = op_a_i + op_b_i;
            ALU_SUB:  result_o = op_a_i - op_b_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result_o = op_a_i ^ op_b_i;
            ALU_OR:   result_o = op_a_i | op_b_i;
            ALU_AND:  result_o = op_a_i & op_b_i;
            // Shift results come from the serial shifter
            default:  result_o = '0;
        endcase
    end

endmodule

// File: hw/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder
    import rv_exec_pkg::*;
(
    input  logic [1:0] alu_op_i,      // Class from main decoder
    input  logic [2:0] funct3_i,      // funct3 field
    input  logic [6:0] funct7_i,      // funct7 field
    output logic [3:0] alu_control_o, // ALU control code
    output logic       illegal_o      // Bad funct7 for this funct3
);

    always_comb begin
        alu_control_o = ALU_ZERO;
        illegal_o     = 1'b0;
        case (alu_op_i)
            ALUOP_ITYPE: begin
                case (funct3_i)
                    3'h0: alu_control_o = ALU_ADD;  // ADDI
                    3'h2: alu_control_o = ALU_SLT;  // SLTI
                    3'h3: alu_control_o = ALU_SLTU; // SLTIU
                    3'h4: alu_control_o = ALU_XOR;  // XORI
                    3'h6: alu_control_o = ALU_OR;   // ORI
                    3'h7: alu_control_o = ALU_AND;  // ANDI
                    3'h1: begin
                        if (funct7_i == 7'h00) alu_control_o = ALU_SLL; // SLLI
                        else illegal_o = 1'b1;
                    end
                    3'h5: begin
                        if (funct7_i == 7'h00) alu_control_o = ALU_SRL; // SRLI
                        else if (funct7_i == FUNCT7_ALT) alu_control_o = ALU_SRA;
                        else illegal_o = 1'b1;
                    end
                    default: alu_control_o = ALU_ZERO;
                endcase
            end

            ALUOP_BRANCH: alu_control_o = ALU_SUB; // Compare operands

            ALUOP_RTYPE: begin
                // Only ADD/SUB and SRL/SRA accept the alternate funct7
                if (funct7_i == FUNCT7_ALT) begin
                    case (funct3_i)
                        3'h0:    alu_control_o = ALU_SUB;
                        3'h5:    alu_control_o = ALU_SRA;
                        default: illegal_o     = 1'b1;
                    endcase
                end else if (funct7_i == 7'h00) begin
                    case (funct3_i)
                        3'h0:    alu_control_o = ALU_ADD;
                        3'h1:    alu_control_o = ALU_SLL;
                        3'h2:    alu_control_o = ALU_SLT;
                        3'h3:    alu_control_o = ALU_SLTU;
                        3'h4:    alu_control_o = ALU_XOR;
                        3'h5:    alu_control_o = ALU_SRL;
                        3'h6:    alu_control_o = ALU_OR;
                        3'h7:    alu_control_o = ALU_AND;
                        default: alu_control_o = ALU_ZERO;
                    endcase
                end else begin
                    illegal_o = 1'b1; // Unknown funct7
                end
            end

            ALUOP_STORE: alu_control_o = ALU_ADD; // Base plus offset

            default: alu_control_o = ALU_ZERO;
        endcase
    end

endmodule

// File: hw/exec_fsm.sv
`timescale 1ns/1ps

module exec_fsm
    import rv_exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       start_i,       // Start strobe
    input  logic [3:0] alu_control_i, // Decoded ALU code
    input  logic       illegal_i,     // Either decoder flagged
    input  logic       cnt_zero_i,    // No shift steps left
    output logic       busy_o,
    output logic       capture_o,     // Load instruction and operands
    output logic       shift_load_o,  // Load shifter and counter
    output logic       shift_en_o,    // One shift step
    output logic       result_load_o, // Load result and illegal regs
    output logic       done_o
);

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       is_shift;

    assign is_shift = (alu_control_i == ALU_SLL) || (alu_control_i == ALU_SRL) ||
                      (alu_control_i == ALU_SRA);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) state_q <= ST_IDLE;
        else           state_q <= state_d;
    end

    always_comb begin
        state_d       = state_q;
        capture_o     = 1'b0;
        shift_load_o  = 1'b0;
        shift_en_o    = 1'b0;
        result_load_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                capture_o = start_i; // Only place a start is accepted
                if (start_i) state_d = ST_EXEC;
            end
            ST_EXEC: begin
                if (illegal_i || !is_shift) begin
                    result_load_o = 1'b1;
                    state_d       = ST_DONE;
                end else begin
                    shift_load_o = 1'b1;
                    state_d      = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                if (cnt_zero_i) begin
                    result_load_o = 1'b1;
                    state_d       = ST_DONE;
                end else begin
                    shift_en_o = 1'b1;
                end
            end
            default: state_d = ST_IDLE; // DONE lasts one cycle
        endcase
    end

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = (state_q == ST_DONE);

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import rv_exec_pkg::*;
(
    input  instr_u            instr_i,   // Captured instruction word
    output logic [1:0]        alu_op_o,  // ALU operation class
    output logic              use_imm_o, // Operand B from immediate
    output logic [XLEN-1:0]   imm_o,     // Sign-extended I immediate
    output logic              illegal_o  // Opcode not supported
);

    // I-type immediate, sign bit is instruction bit 31
    assign imm_o = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    always_comb begin
        alu_op_o  = ALUOP_ITYPE;
        use_imm_o = 1'b0;
        illegal_o = 1'b0;
        case (instr_i.i.opcode)
            OPC_OP_IMM: begin
                alu_op_o  = ALUOP_ITYPE;
                use_imm_o = 1'b1;
            end
            OPC_OP: begin
                alu_op_o  = ALUOP_RTYPE;
            end
            OPC_BRANCH: begin
                alu_op_o  = ALUOP_BRANCH; // rs1 - rs2
            end
            // Store goes through the ALU as rs1 + rs2 only, the split
            // S-type immediate is not assembled in this unit
            OPC_STORE: begin
                alu_op_o  = ALUOP_STORE;
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// File: hw/rv_exec_pkg.sv
package rv_exec_pkg;

    // Data path widths
    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;

    // Major opcodes handled by the unit
    localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // I-type ALU
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Compare via SUB
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // Address via ADD

    // ALU operation class from the main decoder
    localparam logic [1:0] ALUOP_ITYPE  = 2'd0;
    localparam logic [1:0] ALUOP_BRANCH = 2'd1;
    localparam logic [1:0] ALUOP_RTYPE  = 2'd2;
    localparam logic [1:0] ALUOP_STORE  = 2'd3;

    // ALU control codes
    localparam logic [3:0] ALU_ADD  = 4'h0;
    localparam logic [3:0] ALU_SUB  = 4'h1;
    localparam logic [3:0] ALU_SLL  = 4'h2;
    localparam logic [3:0] ALU_SLT  = 4'h3;
    localparam logic [3:0] ALU_SLTU = 4'h4;
    localparam logic [3:0] ALU_SRL  = 4'h5;
    localparam logic [3:0] ALU_SRA  = 4'h6;
    localparam logic [3:0] ALU_OR   = 4'h7;
    localparam logic [3:0] ALU_XOR  = 4'h8;
    localparam logic [3:0] ALU_AND  = 4'h9;
    localparam logic [3:0] ALU_ZERO = 4'hA; // Result forced to zero

    // funct7 value selecting SUB and SRA
    localparam logic [6:0] FUNCT7_ALT = 7'h20;

    // Control FSM state encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_SHIFT = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // I-type field layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// File: hw/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            start_i,   // Start strobe, dropped while busy
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    output logic            busy_o,
    output logic            done_o,    // One-cycle completion pulse
    output logic [XLEN-1:0] result_o,  // Held until next done
    output logic            illegal_o
);

    instr_u          instr_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] result_q;
    logic            illegal_q;
    logic [1:0]      alu_op;
    logic            use_imm;
    logic [XLEN-1:0] imm;
    logic            opc_illegal;
    logic [3:0]      alu_control;
    logic            fn_illegal;
    logic            illegal;
    logic            capture;
    logic            shift_load;
    logic            shift_en;
    logic            result_load;
    logic            cnt_zero;
    logic            is_shift;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] shift_data;
    logic [XLEN-1:0] result_d;

    // Operand capture, gated by the FSM's IDLE state
    always_ff @(posedge clk_i) begin
        if (capture) begin
            instr_q <= instr_i;
            rs1_q   <= rs1_i;
            rs2_q   <= rs2_i;
        end
    end

    instr_decoder u_instr_dec (.instr_i(instr_q), .alu_op_o(alu_op), .use_imm_o(use_imm),
                               .imm_o(imm), .illegal_o(opc_illegal));

    alu_decoder u_alu_dec (.alu_op_i(alu_op), .funct3_i(instr_q.r.funct3),
                           .funct7_i(instr_q.r.funct7), .alu_control_o(alu_control),
                           .illegal_o(fn_illegal));

    assign illegal  = opc_illegal | fn_illegal;
    assign op_b     = use_imm ? imm : rs2_q;
    assign is_shift = (alu_control == ALU_SLL) || (alu_control == ALU_SRL) ||
                      (alu_control == ALU_SRA);

    exec_fsm u_fsm (.clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(start_i),
                    .alu_control_i(alu_control), .illegal_i(illegal), .cnt_zero_i(cnt_zero),
                    .busy_o(busy_o), .capture_o(capture), .shift_load_o(shift_load),
                    .shift_en_o(shift_en), .result_load_o(result_load), .done_o(done_o));

    shift_counter u_cnt (.clk_i(clk_i), .arst_n_i(arst_n_i), .load_i(shift_load),
                         .amount_i(op_b[SHAMT_W-1:0]), .dec_i(shift_en), .zero_o(cnt_zero));

    serial_shifter u_shifter (.clk_i(clk_i), .arst_n_i(arst_n_i), .load_i(shift_load),
                              .en_i(shift_en), .data_i(rs1_q), .alu_control_i(alu_control),
                              .data_o(shift_data));

    alu_core u_alu (.op_a_i(rs1_q), .op_b_i(op_b), .alu_control_i(alu_control),
                    .result_o(alu_result));

    // Illegal wins, then shifter for shift codes
    assign result_d = illegal  ? '0 :
                      is_shift ? shift_data : alu_result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q  <= '0;
            illegal_q <= 1'b0;
        end else if (result_load) begin
            result_q  <= result_d;
            illegal_q <= illegal;
        end
    end

    assign result_o  = result_q;
    assign illegal_o = illegal_q;

endmodule

// File: hw/serial_shifter.sv
`timescale 1ns/1ps

module serial_shifter
    import rv_exec_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            load_i,        // Take new operand
    input  logic            en_i,          // Shift one position
    input  logic [XLEN-1:0] data_i,        // Value to shift
    input  logic [3:0]      alu_control_i, // Selects direction and fill
    output logic [XLEN-1:0] data_o
);

    logic [XLEN-1:0] data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= '0;
        end else if (load_i) begin
            data_q <= data_i;
        end else if (en_i) begin
            case (alu_control_i)
                ALU_SLL: data_q <= {data_q[XLEN-2:0], 1'b0};
                ALU_SRL: data_q <= {1'b0, data_q[XLEN-1:1]};
                ALU_SRA: data_q <= {data_q[XLEN-1], data_q[XLEN-1:1]}; // Sign fill
                default: data_q <= data_q;
            endcase
        end
    end

    assign data_o = data_q;

endmodule

// File: hw/shift_counter.sv
`timescale 1ns/1ps

module shift_counter
    import rv_exec_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               load_i,   // Load new amount
    input  logic [SHAMT_W-1:0] amount_i, // Shift amount
    input  logic               dec_i,    // Step taken
    output logic               zero_o    // Nothing left to shift
);

    logic [SHAMT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= amount_i;
        end else if (dec_i && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 1'b1; // Never wraps below zero
        end
    end

    assign zero_o = (cnt_q == '0);

endmodule
